// File: typecm_link.f
common/typecm_pkg.sv
tx/tx_frame_buffer.sv
tx/tx_serializer.sv
rx/rx_deserializer.sv
logic/typecm_link.sv
tb/tb_typecm_link.sv

// File: Bender.yml
package:
  name: typecm_link

sources:
  - files:
      - common/typecm_pkg.sv
      - tx/tx_frame_buffer.sv
      - tx/tx_serializer.sv
      - rx/rx_deserializer.sv
      - logic/typecm_link.sv
  - target: test
    files:
      - tb/tb_typecm_link.sv

// File: tb/tb_typecm_link.sv
module tb_typecm_link;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES = 52;
    localparam int TIMEOUT_CYCLES =
        NUM_FRAMES * (8 * (typecm_pkg::FIFO_DEPTH + 1) + 4) * 2 + 400;

    logic              clk = 1'b0;
    logic              rst;
    typecm_pkg::byte_t in_data;
    logic              in_valid;
    logic              in_last;
    logic              in_ready;
    logic              tx_en;
    logic              tx_data;
    logic              corrupt_bit = 1'b0;
    typecm_pkg::byte_t out_data;
    logic              out_valid;
    logic              out_last;

    // model of what is still due on the line and at the output
    typecm_pkg::byte_t wire_data [$];
    int                wire_len [$];
    typecm_pkg::byte_t exp_data [$];
    logic              exp_last [$];
    string             exp_test [$];
    logic              corrupt_frame [NUM_FRAMES + 1];
    typecm_pkg::byte_t line_shift;
    int                frame_idx = 0;
    int                line_frame = 0;
    int                line_bits = 0;
    int                stall_cnt = 0;
    int                exp_total = 0;
    int                rx_total = 0;
    int                check_cnt = 0;
    int                err_cnt = 0;
    int                cycle_cnt = 0;
    string             test_name = "reset";

    // loopback from the transmit pins to the receive pins
    typecm_link i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .tx_en     (tx_en),
        .tx_data   (tx_data),
        .rx_en     (tx_en),
        .rx_data   (tx_data ^ corrupt_bit),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        assert (expected === actual) else begin
            err_cnt++;
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        err_cnt++;
        $display("%s", what);
    endtask

    task automatic send_frame(input int len, input logic use_gaps, input logic corrupt);
        int                i;
        int                gap;
        typecm_pkg::byte_t value;
        corrupt_frame[frame_idx] = corrupt;
        for (i = 0; i < len; i++) begin
            gap = use_gaps ? $urandom_range(0, 3) : 0;
            if (gap != 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            value = typecm_pkg::byte_t'($urandom_range(0, 255));
            in_data  <= value;
            in_valid <= 1'b1;
            in_last  <= (i == len - 1);
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            // the byte was taken on this edge
            wire_data.push_back(value);
            if (!corrupt) begin
                exp_data.push_back(value);
                exp_last.push_back(i == len - 1);
                exp_test.push_back(test_name);
                exp_total++;
            end
        end
        wire_len.push_back(len);
        frame_idx++;
    endtask

    // the line checker also inverts the sync bits of chosen frames up to the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            corrupt_bit = 1'b0;
        end else if (tx_en) begin
            corrupt_bit = (line_bits < 8) && corrupt_frame[line_frame];
            line_shift = {line_shift[6:0], tx_data};
            line_bits++;
            if (line_bits == 8) begin
                check_value("wire_format sync", typecm_pkg::SYNC_BYTE, line_shift);
            end else if (line_bits % 8 == 0) begin
                assert (wire_data.size() != 0)
                    else report_failure("tx_en stayed high with no byte left to send");
                if (wire_data.size() != 0) begin
                    check_value("wire_format data", wire_data.pop_front(), line_shift);
                end
            end
        end else begin
            corrupt_bit = 1'b0;
            if (line_bits != 0) begin
                assert (wire_len.size() != 0)
                    else report_failure("a frame went out on the line that was never accepted");
                if (wire_len.size() != 0) begin
                    check_value("wire_format length", 8 * (wire_len.pop_front() + 1), line_bits);
                end
                line_bits = 0;
                line_frame++;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (in_valid && !in_ready) begin
                stall_cnt++;
            end
            assert (!out_last || out_valid)
                else report_failure("out_last was high without out_valid");
            if (out_valid) begin
                rx_total++;
                assert (exp_data.size() != 0)
                    else report_failure("a byte came out of the link with no frame expected");
                if (exp_data.size() != 0) begin
                    check_value({exp_test[0], " out_data"}, exp_data.pop_front(), out_data);
                    check_value({exp_test.pop_front(), " out_last"}, exp_last.pop_front(),
                                out_last);
                end
            end
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        err_cnt++;
        $display("timeout after %0d cycles with %0d bytes still due at the output",
                 cycle_cnt, exp_data.size());
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int k;
        void'($urandom(32'h89b4));
        for (k = 0; k <= NUM_FRAMES; k++) begin
            corrupt_frame[k] = 1'b0;
        end
        rst      = 1'b1;
        in_data  = '0;
        in_valid = 1'b0;
        in_last  = 1'b0;

        @(posedge clk);
        for (k = 0; k < 6; k++) begin
            @(negedge clk);
            check_value("reset tx_en", 0, tx_en);
            check_value("reset out_valid", 0, out_valid);
            check_value("reset out_last", 0, out_last);
            if (k == 3) begin
                @(posedge clk);
                rst <= 1'b0;
            end
        end
        @(posedge clk);

        test_name = "round_trip";
        for (k = 0; k < 40; k++) begin
            send_frame($urandom_range(1, typecm_pkg::FIFO_DEPTH), 1'b1, 1'b0);
        end

        // valid held high across frames fills the buffer faster than the line drains it
        test_name = "back_pressure";
        stall_cnt = 0;
        for (k = 0; k < 6; k++) begin
            send_frame($urandom_range(8, typecm_pkg::FIFO_DEPTH), 1'b0, 1'b0);
        end
        assert (stall_cnt != 0)
            else report_failure("in_ready never fell while a burst of frames was offered");

        test_name = "sync_reject";
        for (k = 0; k < 6; k++) begin
            send_frame($urandom_range(1, typecm_pkg::FIFO_DEPTH), 1'b1, k % 2 == 0);
        end
        in_valid <= 1'b0;

        while (wire_len.size() != 0 || exp_data.size() != 0 || line_bits != 0) begin
            @(posedge clk);
        end
        // idle cycles so that a stray byte would still show up
        repeat (20) @(posedge clk);
        check_value("byte_count", exp_total, rx_total);

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: logic/typecm_link.sv
module typecm_link (
    input  logic              clk,
    input  logic              rst,
    input  typecm_pkg::byte_t in_data,
    input  logic              in_valid,
    input  logic              in_last,
    output logic              in_ready,
    output logic              tx_en,
    output logic              tx_data,
    input  logic              rx_en,
    input  logic              rx_data,
    output typecm_pkg::byte_t out_data,
    output logic              out_valid,
    output logic              out_last
);

    logic              frame_ready;
    typecm_pkg::byte_t head_data;
    logic              head_last;
    logic              byte_take;

    tx_frame_buffer u_frame_buffer (
        .clk         (clk),
        .rst         (rst),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_last     (in_last),
        .in_ready    (in_ready),
        .frame_ready (frame_ready),
        .head_data   (head_data),
        .head_last   (head_last),
        .byte_take   (byte_take)
    );

    tx_serializer u_serializer (
        .clk         (clk),
        .rst         (rst),
        .frame_ready (frame_ready),
        .head_data   (head_data),
        .head_last   (head_last),
        .byte_take   (byte_take),
        .line_en     (tx_en),
        .line_data   (tx_data)
    );

    // the receive side only sees the pins and the loopback is made outside
    rx_deserializer u_deserializer (
        .clk       (clk),
        .rst       (rst),
        .line_en   (rx_en),
        .line_data (rx_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

endmodule

// File: rx/rx_deserializer.sv
module rx_deserializer (
    input  logic              clk,
    input  logic              rst,
    input  logic              line_en,
    input  logic              line_data,
    output typecm_pkg::byte_t out_data,
    output logic              out_valid,
    output logic              out_last
);

    typecm_pkg::rx_state_e state;
    typecm_pkg::bit_idx_t  bit_idx;
    typecm_pkg::byte_t     shift_q;
    typecm_pkg::byte_t     shift_next;
    typecm_pkg::byte_t     hold_q;
    logic                  hold_valid;
    logic                  byte_done;

    assign shift_next = {shift_q[6:0], line_data};
    assign byte_done  = line_en && (bit_idx == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= typecm_pkg::hunt;
            bit_idx    <= 3'd7;
            hold_valid <= 1'b0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            hold_valid <= 1'b0;

            // a held byte is released one bit later, when line_en tells whether it was the last
            if (hold_valid) begin
                out_valid <= 1'b1;
                out_last  <= !line_en;
            end

            case (state)
                typecm_pkg::hunt: begin
                    if (line_en) begin
                        bit_idx <= 3'd6;
                        state   <= typecm_pkg::check_sync;
                    end
                end
                typecm_pkg::check_sync: begin
                    if (!line_en) begin
                        state <= typecm_pkg::hunt;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                        if (byte_done) begin
                            if (shift_next == typecm_pkg::SYNC_BYTE) begin
                                state <= typecm_pkg::receive;
                            end else begin
                                state <= typecm_pkg::drop;
                            end
                        end
                    end
                end
                typecm_pkg::receive: begin
                    // ending mid-byte discards the partial bits
                    if (!line_en) begin
                        state <= typecm_pkg::hunt;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                        if (byte_done) begin
                            hold_valid <= 1'b1;
                        end
                    end
                end
                typecm_pkg::drop: begin
                    if (!line_en) begin
                        state <= typecm_pkg::hunt;
                    end
                end
                default: begin
                    state <= typecm_pkg::hunt;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (line_en) begin
            shift_q <= shift_next;
        end
        if (state == typecm_pkg::receive && byte_done) begin
            hold_q <= shift_next;
        end
        if (hold_valid) begin
            out_data <= hold_q;
        end
    end

    a_last_with_valid: assert property (@(posedge clk) disable iff (rst)
        out_last |-> out_valid);

endmodule

// File: tx/tx_serializer.sv
module tx_serializer (
    input  logic              clk,
    input  logic              rst,
    input  logic              frame_ready,
    input  typecm_pkg::byte_t head_data,
    input  logic              head_last,
    output logic              byte_take,
    output logic              line_en,
    output logic              line_data
);

    typecm_pkg::tx_state_e state;
    typecm_pkg::tx_state_e state_next;
    typecm_pkg::bit_idx_t  bit_idx;
    logic                  byte_end;

    assign byte_end = bit_idx == '0;

    always_comb begin
        state_next = state;
        case (state)
            typecm_pkg::idle: begin
                state_next = typecm_pkg::wait_frame;
            end
            typecm_pkg::wait_frame: begin
                if (frame_ready) begin
                    state_next = typecm_pkg::send_sync;
                end
            end
            typecm_pkg::send_sync: begin
                if (byte_end) begin
                    state_next = typecm_pkg::send_data;
                end
            end
            typecm_pkg::send_data: begin
                // the head entry's last flag closes the frame on its bit 0
                if (byte_end && head_last) begin
                    state_next = typecm_pkg::done;
                end
            end
            typecm_pkg::done: begin
                state_next = typecm_pkg::idle;
            end
            default: begin
                state_next = typecm_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= typecm_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // counts 7 down to 0 for every byte on the line and wraps back to 7
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_idx <= 3'd7;
        end else if (line_en) begin
            bit_idx <= bit_idx - 1'b1;
        end else begin
            bit_idx <= 3'd7;
        end
    end

    assign line_en = (state == typecm_pkg::send_sync) || (state == typecm_pkg::send_data);

    always_comb begin
        if (state == typecm_pkg::send_sync) begin
            line_data = typecm_pkg::SYNC_BYTE[bit_idx];
        end else if (state == typecm_pkg::send_data) begin
            line_data = head_data[bit_idx];
        end else begin
            line_data = 1'b0;
        end
    end

    // the head byte is popped while its final bit is still on the line
    assign byte_take = (state == typecm_pkg::send_data) && byte_end;

    // a frame only stays on the line while the buffer still counts it as complete
    a_en_within_frame: assert property (@(posedge clk) disable iff (rst)
        line_en |-> frame_ready);

endmodule

// File: tx/tx_frame_buffer.sv
module tx_frame_buffer (
    input  logic              clk,
    input  logic              rst,
    input  typecm_pkg::byte_t in_data,
    input  logic              in_valid,
    input  logic              in_last,
    output logic              in_ready,
    output logic              frame_ready,
    output typecm_pkg::byte_t head_data,
    output logic              head_last,
    input  logic              byte_take
);

    typecm_pkg::byte_t     data_mem [typecm_pkg::FIFO_DEPTH];
    logic                  last_mem [typecm_pkg::FIFO_DEPTH];
    typecm_pkg::fifo_ptr_t wr_ptr;
    typecm_pkg::fifo_ptr_t rd_ptr;
    typecm_pkg::fifo_cnt_t entry_cnt;
    typecm_pkg::fifo_cnt_t entry_cnt_next;
    typecm_pkg::fifo_cnt_t frame_cnt;
    typecm_pkg::fifo_cnt_t frame_cnt_next;
    logic                  push;
    logic                  frame_push;
    logic                  frame_pop;

    assign push       = in_valid && in_ready;
    assign frame_push = push && in_last;
    assign frame_pop  = byte_take && head_last;

    always_comb begin
        entry_cnt_next = entry_cnt;
        if (push && !byte_take) begin
            entry_cnt_next = entry_cnt + 1'b1;
        end else if (!push && byte_take) begin
            entry_cnt_next = entry_cnt - 1'b1;
        end
    end

    // a frame counts as complete once its last byte is stored
    always_comb begin
        frame_cnt_next = frame_cnt;
        if (frame_push && !frame_pop) begin
            frame_cnt_next = frame_cnt + 1'b1;
        end else if (!frame_push && frame_pop) begin
            frame_cnt_next = frame_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            entry_cnt <= '0;
            frame_cnt <= '0;
            in_ready  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (byte_take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            entry_cnt <= entry_cnt_next;
            frame_cnt <= frame_cnt_next;
            // ready is registered from the next count so it drops exactly when full
            in_ready  <= entry_cnt_next != typecm_pkg::fifo_cnt_t'(typecm_pkg::FIFO_DEPTH);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_data;
            last_mem[wr_ptr] <= in_last;
        end
    end

    assign head_data   = data_mem[rd_ptr];
    assign head_last   = last_mem[rd_ptr];
    assign frame_ready = frame_cnt != '0;

    // the serializer only pops inside a complete frame, so the buffer is never empty then
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        byte_take |-> entry_cnt != '0);

    a_frames_le_entries: assert property (@(posedge clk) disable iff (rst)
        frame_cnt <= entry_cnt);

endmodule

// File: common/typecm_pkg.sv
package typecm_pkg;

    // one data byte as carried on the input stream, the line and the output stream
    typedef logic [7:0] byte_t;

    // every frame on the line starts with this byte
    localparam byte_t SYNC_BYTE = 8'h01;

    // buffer entries, which is also the longest frame the link accepts
    localparam int FIFO_DEPTH = 16;

    typedef logic [3:0] fifo_ptr_t;
    typedef logic [4:0] fifo_cnt_t;

    // position of a bit within a byte, counted down from 7 (MSB first)
    typedef logic [2:0] bit_idx_t;

    typedef enum logic [2:0] {
        idle,
        wait_frame,
        send_sync,
        send_data,
        done
    } tx_state_e;

    typedef enum logic [1:0] {
        hunt,
        check_sync,
        receive,
        drop
    } rx_state_e;

endpackage
